/* src.f */
logic/conv_pkg.sv
logic/mac.sv
logic/weight_rom.sv
logic/requant_relu.sv
logic/layer_sequencer.sv
logic/conv_layer.sv
dv/conv_layer_assert.sv
dv/conv_layer_tb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run the testbench, judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=conv_layer_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module conv_layer_tb \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

/* dv/conv_layer_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_layer_tb;

	logic clk = 1'b0;
	logic rst_n;
	logic layer_en;
	logic [conv_pkg::WIDTH-1:0] ifm;
	logic ram_feedback;
	logic [conv_pkg::WIDTH-1:0] ofm [conv_pkg::NUM_LANES];
	logic sample;
	logic finish;

	// High in the cycle that presents a window's last counted beat
	logic last_beat_mark;

	// Expected ofm per window with all lanes packed
	logic [conv_pkg::NUM_LANES*conv_pkg::WIDTH-1:0] exp_q [$];
	logic [conv_pkg::NUM_LANES*conv_pkg::WIDTH-1:0] exp_head = '0;
	int model_acc [conv_pkg::NUM_LANES];
	int beat_idx;
	int windows_sent;
	logic [31:0] rng = 32'd49219;

	// Observed samples and feedback since reset
	int sample_cnt;
	logic fb_model;
	logic finish_exp;
	// Last beat marks on their way to the ofm update
	logic [2:0] mark_pipe;
	int windows_done;

	int err_cnt = 0;
	int err_base;
	int tests_run = 0;
	int tests_failed = 0;
	logic timeout_hit = 1'b0;
	string timeout_reason;

	always #20 clk = ~clk;

	conv_layer UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.ofm          (ofm),
		.sample       (sample),
		.finish       (finish)
	);

	////////////////////
	// Reference model
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ReLU, then bits FRAC_BITS+14 down to FRAC_BITS under a zero sign
	function automatic logic [conv_pkg::WIDTH-1:0] requant(input int s);
		logic [conv_pkg::ACC_WIDTH-1:0] bits;
		bits = s;
		if (bits[conv_pkg::ACC_WIDTH-1]) return '0;
		return {1'b0, bits[conv_pkg::FRAC_BITS+14:conv_pkg::FRAC_BITS]};
	endfunction

	function automatic logic [conv_pkg::WIDTH-1:0] pattern_pixel(input int w, input int b);
		// Zero pixels leave bias alone, so low lanes go negative
		if (w == 0) return '0;
		if (w == 1) return 16'd255;
		return (b % 2 == 0) ? 16'd255 : 16'd3;
	endfunction

	function automatic int total_errors();
		return err_cnt + UUT.u_assert.fail_cnt;
	endfunction

	task automatic push_window();
		logic [conv_pkg::NUM_LANES*conv_pkg::WIDTH-1:0] word;
		logic [conv_pkg::WIDTH-1:0] lane_out;
		for (int l = 0; l < conv_pkg::NUM_LANES; l++) begin
			lane_out = requant(model_acc[l] + int'(conv_pkg::bias_of(l)));
			word[l*conv_pkg::WIDTH +: conv_pkg::WIDTH] = lane_out;
			model_acc[l] = 0;
		end
		exp_q.push_back(word);
		exp_head = exp_q[0];
	endtask

	////////////////////
	// Stimulus
	////////////////////

	// One beat; the model only follows beats of the layer's windows
	task automatic drive_beat(input logic [conv_pkg::WIDTH-1:0] p);
		logic last;
		last = 1'b0;
		if (windows_sent < conv_pkg::NUM_WINDOWS) begin
			for (int l = 0; l < conv_pkg::NUM_LANES; l++) begin
				model_acc[l] += int'(p) * int'(conv_pkg::weight_of(l, beat_idx));
			end
			beat_idx++;
			if (beat_idx == conv_pkg::WINDOW_BEATS) begin
				beat_idx = 0;
				windows_sent++;
				last = 1'b1;
				push_window();
			end
		end
		@(posedge clk);
		layer_en       <= 1'b1;
		ifm            <= p;
		last_beat_mark <= last;
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			layer_en       <= 1'b0;
			last_beat_mark <= 1'b0;
		end
	endtask

	// Pixels kept to 0..255 so no sum overflows
	task automatic drive_random_beats(input int n, input logic gapped);
		for (int i = 0; i < n; i++) begin
			rng = xorshift32(rng);
			if (gapped && rng[9:8] == 2'd0) idle(1 + int'(rng[13:12]));
			drive_beat({8'd0, rng[7:0]});
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n          <= 1'b0;
		layer_en       <= 1'b0;
		ram_feedback   <= 1'b0;
		last_beat_mark <= 1'b0;
		exp_q.delete();
		exp_head = '0;
		beat_idx = 0;
		windows_sent = 0;
		for (int l = 0; l < conv_pkg::NUM_LANES; l++) model_acc[l] = 0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	////////////////////
	// Waits and report
	////////////////////

	// Parks the sequence until the watchdog ends the run
	task automatic hold_on_timeout(input string what);
		timeout_reason = what;
		timeout_hit = 1'b1;
		forever @(posedge clk);
	endtask

	task automatic wait_samples(input int n, input int limit);
		int cycles;
		cycles = 0;
		while (sample_cnt < n) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) hold_on_timeout("expected sample strobe never came");
		end
	endtask

	task automatic wait_finish(input logic level, input int limit);
		int cycles;
		cycles = 0;
		while (finish !== level) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) hold_on_timeout("finish did not reach the expected level");
		end
	endtask

	task automatic begin_test();
		err_base = total_errors();
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = total_errors() - err_base;
		tests_run++;
		if (errs != 0) tests_failed++;
		$display("Test %0d %s: %s, %0d errors", tests_run, name,
			(errs == 0) ? "ok" : "bad", errs);
	endtask

	////////////////////
	// Checking
	////////////////////

	// Sample count, expected queue, feedback latch and window count
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_cnt   <= 0;
			fb_model     <= 1'b0;
			mark_pipe    <= '0;
			windows_done <= 0;
		end else begin
			if (ram_feedback) fb_model <= 1'b1;
			mark_pipe <= {mark_pipe[1:0], last_beat_mark};
			if (mark_pipe[2]) windows_done <= windows_done + 1;
			if (sample) begin
				sample_cnt <= sample_cnt + 1;
				if (exp_q.size() > 0) void'(exp_q.pop_front());
				exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
			end
		end
	end

	// Finish high once the model's last window lands, until feedback
	assign finish_exp = !fb_model && (windows_done == conv_pkg::NUM_WINDOWS);

	for (genvar l = 0; l < conv_pkg::NUM_LANES; l++) begin : g_chk
		ofm_matches: assert property (@(posedge clk) disable iff (!rst_n)
			sample |-> (ofm[l] == exp_head[l*conv_pkg::WIDTH +: conv_pkg::WIDTH])
		) else begin
			$display("CHECK FAILED: ofm[%0d] = 0x%04h, expected 0x%04h", l,
				$sampled(ofm[l]), $sampled(exp_head[l*conv_pkg::WIDTH +: conv_pkg::WIDTH]));
			err_cnt++;
		end

		// ofm moves only with a new result
		ofm_holds: assert property (@(posedge clk) disable iff (!rst_n)
			!sample |-> (ofm[l] == $past(ofm[l]))
		) else begin
			$display("CHECK FAILED: ofm[%0d] = 0x%04h, expected 0x%04h", l,
				$sampled(ofm[l]), $past(ofm[l]));
			err_cnt++;
		end
	end

	// Strobe exactly four cycles after each last beat
	sample_timing: assert property (@(posedge clk) disable iff (!rst_n)
		sample == $past(last_beat_mark, 4)
	) else begin
		$display("CHECK FAILED: sample = 0x%0h, expected 0x%0h",
			$sampled(sample), !$sampled(sample));
		err_cnt++;
	end

	finish_level: assert property (@(posedge clk) disable iff (!rst_n)
		finish == finish_exp
	) else begin
		$display("CHECK FAILED: finish = 0x%0h, expected 0x%0h",
			$sampled(finish), $sampled(finish_exp));
		err_cnt++;
	end

	initial begin
		wait (timeout_hit);
		$display("Timeout: %s", timeout_reason);
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		rst_n = 1'b0;
		layer_en = 1'b0;
		ifm = '0;
		ram_feedback = 1'b0;
		last_beat_mark = 1'b0;
		apply_reset();

		begin_test();
		drive_random_beats(3 * conv_pkg::WINDOW_BEATS, 1'b0);
		idle(6);
		wait_samples(3, 20);
		end_test("continuous windows");

		begin_test();
		drive_random_beats(3 * conv_pkg::WINDOW_BEATS, 1'b1);
		idle(6);
		wait_samples(6, 20);
		end_test("gapped beats");

		// Zero pixels, full scale, then alternating
		begin_test();
		for (int w = 0; w < 3; w++) begin
			for (int b = 0; b < conv_pkg::WINDOW_BEATS; b++) drive_beat(pattern_pixel(w, b));
		end
		idle(6);
		wait_samples(9, 20);
		end_test("relu and bias");

		// Beats past the layer end are dropped
		begin_test();
		wait_finish(1'b1, 10);
		drive_random_beats(2 * conv_pkg::WINDOW_BEATS, 1'b0);
		idle(10);
		end_test("layer end");

		begin_test();
		@(posedge clk);
		ram_feedback <= 1'b1;
		@(posedge clk);
		ram_feedback <= 1'b0;
		wait_finish(1'b0, 10);
		idle(20);
		apply_reset();
		drive_random_beats(conv_pkg::NUM_WINDOWS * conv_pkg::WINDOW_BEATS, 1'b0);
		idle(6);
		wait_samples(conv_pkg::NUM_WINDOWS, 20);
		wait_finish(1'b1, 10);
		idle(4);
		end_test("feedback");

		$display("Summary: %0d tests, %0d failed, %0d check errors",
			tests_run, tests_failed, total_errors());
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/conv_layer_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_layer_assert (
	input logic clk,
	input logic rst_n,
	input logic sample,
	input logic finish
);

	// Failures seen, read back by the testbench
	int fail_cnt = 0;
	// Finish has been high since reset
	logic finish_seen;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) finish_seen <= 1'b0;
		else if (finish) finish_seen <= 1'b1;
	end

	////////////////////
	// Strobe shape
	////////////////////

	// One cycle per window result
	sample_one_cycle: assert property (
		@(posedge clk) disable iff (!rst_n) sample |=> !sample
	) else begin
		$error("sample stayed high for more than one cycle");
		fail_cnt++;
	end

	// Outputs quiet while reset is held
	reset_quiet: assert property (
		@(posedge clk) !rst_n |-> (!sample && !finish)
	) else begin
		$error("sample or finish high during reset");
		fail_cnt++;
	end

	////////////////////
	// Layer end
	////////////////////

	// No new result once the layer has ended
	no_sample_after_finish: assert property (
		@(posedge clk) disable iff (!rst_n) $rose(sample) |-> !finish_seen
	) else begin
		$error("sample rose after finish had gone high");
		fail_cnt++;
	end

	// Dropped finish stays low until reset
	finish_stays_low: assert property (
		@(posedge clk) disable iff (!rst_n) (finish_seen && !finish) |=> !finish
	) else begin
		$error("finish rose again without a reset");
		fail_cnt++;
	end

endmodule

bind conv_layer conv_layer_assert u_assert (
	.clk    (clk),
	.rst_n  (rst_n),
	.sample (sample),
	.finish (finish)
);

`default_nettype wire

/* logic/conv_layer.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_layer (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       layer_en,
	input  logic [conv_pkg::WIDTH-1:0] ifm,
	input  logic                       ram_feedback,
	output logic [conv_pkg::WIDTH-1:0] ofm [conv_pkg::NUM_LANES],
	output logic                       sample,
	output logic                       finish
);

	// Sequencer to ROM and lanes
	logic [conv_pkg::ADDR_WIDTH-1:0] rom_addr;
	logic [conv_pkg::WIDTH-1:0] pix_q;
	logic beat_en_q;
	logic acc_clr;
	// Registered weights, one per lane
	logic signed [conv_pkg::WIDTH-1:0] weights [conv_pkg::NUM_LANES];
	// Lane sums into the output stage
	logic signed [conv_pkg::ACC_WIDTH-1:0] acc [conv_pkg::NUM_LANES];

	////////////////////
	// Control
	////////////////////

	layer_sequencer u_seq (
		.clk          (clk),
		.rst_n        (rst_n),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.rom_addr     (rom_addr),
		.pix_q        (pix_q),
		.beat_en_q    (beat_en_q),
		.acc_clr      (acc_clr),
		.sample       (sample),
		.finish       (finish)
	);

	weight_rom u_rom (
		.clk     (clk),
		.rst_n   (rst_n),
		.addr    (rom_addr),
		.weights (weights)
	);

	////////////////////
	// MAC lanes
	////////////////////

	// Same pixel broadcast to every lane
	for (genvar l = 0; l < conv_pkg::NUM_LANES; l++) begin : g_lane
		mac u_mac (
			.clk   (clk),
			.rst_n (rst_n),
			.clr   (acc_clr),
			.en    (beat_en_q),
			.pix   (pix_q),
			.ker   (weights[l]),
			.acc   (acc[l])
		);
	end

	// Bias, ReLU and requantization
	requant_relu u_out (
		.clk   (clk),
		.rst_n (rst_n),
		.clr   (acc_clr),
		.acc   (acc),
		.ofm   (ofm)
	);

endmodule

`default_nettype wire

/* logic/layer_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module layer_sequencer (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            layer_en,
	input  logic [conv_pkg::WIDTH-1:0]      ifm,
	input  logic                            ram_feedback,
	output logic [conv_pkg::ADDR_WIDTH-1:0] rom_addr,
	output logic [conv_pkg::WIDTH-1:0]      pix_q,
	output logic                            beat_en_q,
	output logic                            acc_clr,
	output logic                            sample,
	output logic                            finish
);

	conv_pkg::seq_state_t state;

	// Accepted beat, layer not yet ended
	logic beat;
	// Delay pipeline toward the lanes
	logic [conv_pkg::WIDTH-1:0] pix_d1;
	logic beat_en_d1;
	// Window clear, ROM side and its first delay
	logic rom_clr;
	logic clr_d1;
	// One window finished in the lanes
	logic window_done;
	logic [$clog2(conv_pkg::NUM_WINDOWS)-1:0] win_cnt;
	// Downstream buffer has answered
	logic fb_seen;

	assign beat = layer_en && (state != conv_pkg::SEQ_END);

	////////////////////
	// Input delay
	////////////////////

	// Pixel reaches the multiplier two cycles after it enters
	always_ff @(posedge clk) begin
		pix_d1 <= ifm;
		pix_q  <= pix_d1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_en_d1 <= 1'b0;
			beat_en_q  <= 1'b0;
		end else begin
			beat_en_d1 <= beat;
			beat_en_q  <= beat_en_d1;
		end
	end

	////////////////////
	// Beat counter
	////////////////////

	// Address runs on accepted beats only, wraps at the window end
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rom_addr <= '0;
			rom_clr  <= 1'b0;
		end else begin
			rom_clr <= 1'b0;
			if (beat) begin
				if (int'(rom_addr) == conv_pkg::WINDOW_BEATS - 1) begin
					rom_addr <= '0;
					rom_clr  <= 1'b1;
				end else begin
					rom_addr <= rom_addr + 1'b1;
				end
			end
		end
	end

	// Clear delayed twice to meet the first weight of the next window
	// Sample trails the clear by one, when ofm is updated
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clr_d1  <= 1'b0;
			acc_clr <= 1'b0;
			sample  <= 1'b0;
		end else begin
			clr_d1  <= rom_clr;
			acc_clr <= clr_d1;
			sample  <= acc_clr;
		end
	end

	////////////////////
	// Window timer
	////////////////////

	assign window_done = acc_clr && (state == conv_pkg::SEQ_RUN);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= conv_pkg::SEQ_IDLE;
			win_cnt <= '0;
		end else begin
			case (state)
				conv_pkg::SEQ_IDLE: begin
					if (layer_en) state <= conv_pkg::SEQ_RUN;
				end
				conv_pkg::SEQ_RUN: begin
					if (window_done) begin
						win_cnt <= win_cnt + 1'b1;
						// Last window of the layer
						if (int'(win_cnt) == conv_pkg::NUM_WINDOWS - 1) begin
							state <= conv_pkg::SEQ_END;
						end
					end
				end
				// Ended layer waits for reset
				conv_pkg::SEQ_END: state <= conv_pkg::SEQ_END;
				default: state <= conv_pkg::SEQ_IDLE;
			endcase
		end
	end

	////////////////////
	// Finish
	////////////////////

	// Feedback strobe sticks until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) fb_seen <= 1'b0;
		else if (ram_feedback) fb_seen <= 1'b1;
	end

	assign finish = (state == conv_pkg::SEQ_END) && !fb_seen;

endmodule

`default_nettype wire

/* logic/requant_relu.sv */
`timescale 1ns/1ns
`default_nettype none

module requant_relu (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  clr,
	input  logic signed [conv_pkg::ACC_WIDTH-1:0] acc [conv_pkg::NUM_LANES],
	output logic [conv_pkg::WIDTH-1:0]            ofm [conv_pkg::NUM_LANES]
);

	// Accumulator plus bias, per lane
	logic signed [conv_pkg::ACC_WIDTH-1:0] sum [conv_pkg::NUM_LANES];

	////////////////////
	// Bias add
	////////////////////

	always_comb begin
		for (int l = 0; l < conv_pkg::NUM_LANES; l++) begin
			sum[l] = acc[l] + conv_pkg::bias_of(l);
		end
	end

	////////////////////
	// ReLU and requant
	////////////////////

	// Clear edge holds the finished sum of the previous window
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int l = 0; l < conv_pkg::NUM_LANES; l++) begin
				ofm[l] <= '0;
			end
		end else if (clr) begin
			for (int l = 0; l < conv_pkg::NUM_LANES; l++) begin
				if (sum[l][conv_pkg::ACC_WIDTH-1]) begin
					// Negative sum clamps to zero
					ofm[l] <= '0;
				end else begin
					// No saturation, upper bits simply dropped
					ofm[l] <= {1'b0,
						sum[l][conv_pkg::FRAC_BITS+conv_pkg::WIDTH-2:conv_pkg::FRAC_BITS]};
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/weight_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module weight_rom (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [conv_pkg::ADDR_WIDTH-1:0]      addr,
	output logic signed [conv_pkg::WIDTH-1:0]    weights [conv_pkg::NUM_LANES]
);

	// Constant table, one row per lane
	logic signed [conv_pkg::WIDTH-1:0] rom_table [conv_pkg::NUM_LANES][conv_pkg::WINDOW_BEATS];
	// ROM output register
	logic signed [conv_pkg::WIDTH-1:0] rom_q [conv_pkg::NUM_LANES];

	////////////////////
	// Table contents
	////////////////////

	// Filled at elaboration from the package rule
	for (genvar l = 0; l < conv_pkg::NUM_LANES; l++) begin : g_lane
		for (genvar a = 0; a < conv_pkg::WINDOW_BEATS; a++) begin : g_addr
			assign rom_table[l][a] = conv_pkg::weight_of(l, a);
		end
	end

	////////////////////
	// Read pipeline
	////////////////////

	// Two stages, so the weight meets the twice delayed pixel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int l = 0; l < conv_pkg::NUM_LANES; l++) begin
				rom_q[l]   <= '0;
				weights[l] <= '0;
			end
		end else begin
			for (int l = 0; l < conv_pkg::NUM_LANES; l++) begin
				// Address never passes WINDOW_BEATS-1
				rom_q[l]   <= rom_table[l][addr];
				// Kernel register in front of the lane
				weights[l] <= rom_q[l];
			end
		end
	end

endmodule

`default_nettype wire

/* logic/mac.sv */
`timescale 1ns/1ns
`default_nettype none

module mac (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  clr,
	input  logic                                  en,
	input  logic signed [conv_pkg::WIDTH-1:0]     pix,
	input  logic signed [conv_pkg::WIDTH-1:0]     ker,
	output logic signed [conv_pkg::ACC_WIDTH-1:0] acc
);

	// Full precision product, both operands sign extended
	logic signed [conv_pkg::ACC_WIDTH-1:0] prod;

	assign prod = pix * ker;

	////////////////////
	// Accumulator
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (clr) begin
			// First beat of the next window, loaded instead of added
			// Idle cycle on the clear starts the window from zero
			acc <= en ? prod : '0;
		end else if (en) begin
			acc <= acc + prod;
		end
		// Otherwise hold across idle cycles
	end

endmodule

`default_nettype wire

/* logic/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	////////////////////
	// Layer geometry
	////////////////////

	// Pixel, weight and output word
	localparam int WIDTH = 16;
	// Product, accumulator and bias word
	localparam int ACC_WIDTH = 2 * WIDTH;

	// One MAC lane per output channel
	localparam int NUM_LANES = 8;
	localparam int CHIN = 4;
	localparam int KERNEL_DIM = 3;
	// Beats in one kernel window
	localparam int WINDOW_BEATS = KERNEL_DIM * KERNEL_DIM * CHIN;
	localparam int ADDR_WIDTH = $clog2(WINDOW_BEATS);

	// Output map is WOUT by WOUT, one window per output pixel
	localparam int WOUT = 3;
	localparam int NUM_WINDOWS = WOUT * WOUT;
	// Fraction bits dropped when requantizing
	localparam int FRAC_BITS = 14;

	// Sequencer state
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_END
	} seq_state_t;

	////////////////////
	// Constant tables
	////////////////////

	// Weights in -4..4, scaled by 2**10
	function automatic logic signed [WIDTH-1:0] weight_of(input int lane, input int addr);
		int w;
		w = (((lane * 5 + addr * 3) % 9) - 4) * (2 ** 10);
		return WIDTH'(w);
	endfunction

	// Bias per lane, scaled by 2**20
	function automatic logic signed [ACC_WIDTH-1:0] bias_of(input int lane);
		int b;
		b = (lane * 3 - 10) * (2 ** 20);
		return ACC_WIDTH'(b);
	endfunction

endpackage

`default_nettype wire
